//--- bench/tcls_testdata.txt
// Columns: op a b c d e, all hex. 1 drive cores: mask iaddr daddr wdata dreq
// 2 write: addr data. 3 read: addr exp_data exp_err. 4 step: cycles
// 5 state: exp_state exp_setback. 6 bus: iaddr daddr wdata exp_mismatch
// 7 random agree: iterations. 8 fanout: data_rdata instr_rdata flags
// 9 fetch enable: value. a end of test: number. 0 end of records
7 8 0 0 0 0
a 1 0 0 0 0
1 7 1000 2000 11111111 0
6 1000 2000 11111111 0 0
1 2 1004 2000 11111111 0
6 1000 2000 11111111 1 0
5 0 0 0 0 0
4 1 0 0 0 0
3 3 1 0 0 0
5 1 0 0 0 0
1 2 1000 2000 11111111 0
a 2 0 0 0 0
2 0 3 0 0 0
2 1 80000100 0 0 0
5 1 0 0 0 0
4 1 0 0 0 0
5 2 7 0 0 0
4 1 0 0 0 0
5 2 0 0 0 0
3 1 80000100 0 0 0
1 4 1008 2000 11111111 0
6 1000 2000 11111111 1 0
4 1 0 0 0 0
5 2 7 0 0 0
1 4 1000 2000 11111111 0
4 1 0 0 0 0
5 2 0 0 0 0
3 4 0 0 0 0
2 1 0 0 0 0
5 2 0 0 0 0
4 1 0 0 0 0
5 0 0 0 0 0
a 4 0 0 0 0
1 7 1000 2000 11111111 0
1 1 1000 2040 11111111 0
6 1000 2000 11111111 0 0
4 1 0 0 0 0
5 0 0 0 0 0
3 2 0 0 0 0
1 6 1000 2000 11111111 1
1 1 1000 2040 11111111 1
6 1000 2000 11111111 1 0
4 1 0 0 0 0
3 2 1 0 0 0
5 1 0 0 0 0
1 7 1000 2000 11111111 0
a 3 0 0 0 0
9 0 0 0 0 0
4 1 0 0 0 0
5 0 0 0 0 0
9 1 0 0 0 0
8 cafe0123 5a5a0f0f 7 0 0
8 0 ffffffff 2 0 0
a 5 0 0 0 0
3 7 0 1 0 0
2 2 55 0 0 0
3 2 1 0 0 0
3 3 1 0 0 0
3 0 3 0 0 0
a 6 0 0 0 0
0 0 0 0 0 0

//--- vlog.f
source/tcls_pkg.sv
source/tmr_voter.sv
source/tcls_core_vote.sv
source/tcls_regs.sv
source/tcls_recovery_fsm.sv
source/tcls_unit.sv
bench/tcls_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the lock-step unit testbench with Verilator and runs it.
# Exits nonzero when the build fails or the log holds the fail message.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -f vlog.f --top-module tcls_tb -o tcls_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/tcls_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
  echo "Simulation reported a failure"
  exit 1
fi

if ! grep -q "TEST OK" "$LOG"; then
  echo "Simulation ended without a pass message"
  exit 1
fi

exit 0

//--- bench/tcls_tb.sv
/*
 * Testbench for the triple-core lock-step unit.
 * Reads operation records from the test data file and drives the
 * three core request buses, the register port and the interconnect.
 * Responses are compared with the expected values in the records.
 */
`timescale 1ns/1ps
`default_nettype none

module tcls_tb
  import tcls_pkg::*;
();

  localparam int RecWords = 6;
  localparam int MaxRecs  = 128;
  localparam int Margin   = 50;

  logic                          clk;
  logic                          rst_n;
  reg_req_t                      reg_req;
  reg_rsp_t                      reg_rsp;
  logic                          single_mismatch;
  logic                          triple_mismatch;
  red_mode_e                     state;
  logic      [2:0]               core_setback;
  logic      [31:0]              hart_id;
  logic                          fetch_en;
  logic      [31:0]              boot_addr;
  logic      [31:0]              irq;
  logic                          debug_req;
  logic                          irq_ack;
  logic      [4:0]               irq_ack_id;
  logic                          instr_req;
  logic      [31:0]              instr_addr;
  logic                          instr_gnt;
  logic      [31:0]              instr_rdata;
  logic                          instr_rvalid;
  logic                          instr_err;
  logic                          data_req;
  logic      [31:0]              data_addr;
  logic                          data_we;
  logic      [31:0]              data_wdata;
  logic      [3:0]               data_be;
  logic                          data_gnt;
  logic      [31:0]              data_rdata;
  logic                          data_rvalid;
  logic                          data_err;
  main_req_t [2:0]               core_main;
  data_req_t [2:0]               core_data;
  logic      [2:0][31:0]         core_wdata;
  logic      [2:0][3:0]          core_be;
  logic      [2:0][31:0]         core_hart_id;
  logic      [2:0]               core_fetch_en;
  logic      [2:0][31:0]         core_boot_addr;
  logic      [2:0][31:0]         core_irq;
  logic      [2:0]               core_debug_req;
  logic      [2:0]               core_instr_gnt;
  logic      [2:0][31:0]         core_instr_rdata;
  logic      [2:0]               core_instr_rvalid;
  logic      [2:0]               core_instr_err;
  logic      [2:0]               core_data_gnt;
  logic      [2:0][31:0]         core_data_rdata;
  logic      [2:0]               core_data_rvalid;
  logic      [2:0]               core_data_err;

  logic      [31:0]              stim_mem [0:MaxRecs*RecWords-1];
  logic      [31:0]              rec [0:RecWords-1];
  logic      [31:0]              rng_state;
  int                            num_recs;
  int                            max_step;
  int                            timeout_limit = 100000;
  int                            cycle_count;
  int                            check_count;
  int                            error_count;
  int                            test_errors;

  tcls_unit #(
    .DataWidth ( 32 ),
    .BeWidth   ( 4  )
  ) i_dut (
    .clk_i               ( clk               ),
    .rst_ni              ( rst_n             ),
    .reg_req_i           ( reg_req           ),
    .reg_rsp_o           ( reg_rsp           ),
    .single_mismatch_o   ( single_mismatch   ),
    .triple_mismatch_o   ( triple_mismatch   ),
    .state_o             ( state             ),
    .core_setback_o      ( core_setback      ),
    .intc_hart_id_i      ( hart_id           ),
    .intc_fetch_en_i     ( fetch_en          ),
    .intc_boot_addr_i    ( boot_addr         ),
    .intc_irq_i          ( irq               ),
    .intc_debug_req_i    ( debug_req         ),
    .intc_irq_ack_o      ( irq_ack           ),
    .intc_irq_ack_id_o   ( irq_ack_id        ),
    .intc_instr_req_o    ( instr_req         ),
    .intc_instr_addr_o   ( instr_addr        ),
    .intc_instr_gnt_i    ( instr_gnt         ),
    .intc_instr_rdata_i  ( instr_rdata       ),
    .intc_instr_rvalid_i ( instr_rvalid      ),
    .intc_instr_err_i    ( instr_err         ),
    .intc_data_req_o     ( data_req          ),
    .intc_data_addr_o    ( data_addr         ),
    .intc_data_we_o      ( data_we           ),
    .intc_data_wdata_o   ( data_wdata        ),
    .intc_data_be_o      ( data_be           ),
    .intc_data_gnt_i     ( data_gnt          ),
    .intc_data_rdata_i   ( data_rdata        ),
    .intc_data_rvalid_i  ( data_rvalid       ),
    .intc_data_err_i     ( data_err          ),
    .core_main_i         ( core_main         ),
    .core_data_i         ( core_data         ),
    .core_wdata_i        ( core_wdata        ),
    .core_be_i           ( core_be           ),
    .core_hart_id_o      ( core_hart_id      ),
    .core_fetch_en_o     ( core_fetch_en     ),
    .core_boot_addr_o    ( core_boot_addr    ),
    .core_irq_o          ( core_irq          ),
    .core_debug_req_o    ( core_debug_req    ),
    .core_instr_gnt_o    ( core_instr_gnt    ),
    .core_instr_rdata_o  ( core_instr_rdata  ),
    .core_instr_rvalid_o ( core_instr_rvalid ),
    .core_instr_err_o    ( core_instr_err    ),
    .core_data_gnt_o     ( core_data_gnt     ),
    .core_data_rdata_o   ( core_data_rdata   ),
    .core_data_rvalid_o  ( core_data_rvalid  ),
    .core_data_err_o     ( core_data_err     )
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  // Ends the run when the cycle count passes the limit from the records
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > timeout_limit) begin
      $display("Timeout: the run went past %0d cycles without finishing", timeout_limit);
      $display("TEST FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic wait_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      test_errors++;
      $display("FAILED at time %0t: %s, got %h, expected %h", $time, what, actual, expected);
    end
  endtask

  task automatic drive_cores(input logic [31:0] mask, input logic [31:0] iaddr,
                             input logic [31:0] daddr, input logic [31:0] wdata,
                             input logic [31:0] dreq);
    for (int k = 0; k < 3; k++) begin
      if (mask[k]) begin
        core_main[k].irq_ack    = 1'b0;
        core_main[k].irq_ack_id = 5'd0;
        core_main[k].instr_req  = 1'b1;
        core_main[k].instr_addr = iaddr;
        core_main[k].data_req   = dreq[0];
        core_data[k].addr       = daddr;
        core_data[k].we         = 1'b0;
        core_wdata[k]           = wdata;
        core_be[k]              = 4'hf;
      end
    end
  endtask

  // Same random request on every core, so the vote must pass it through
  task automatic drive_random_agree(input int iterations);
    logic [31:0] r_addr;
    logic [31:0] r_ctrl;
    logic [31:0] r_data;
    for (int n = 0; n < iterations; n++) begin
      rng_state = xorshift32(rng_state);
      r_addr    = rng_state;
      rng_state = xorshift32(rng_state);
      r_ctrl    = rng_state;
      rng_state = xorshift32(rng_state);
      r_data    = rng_state;
      for (int k = 0; k < 3; k++) begin
        core_main[k].irq_ack    = r_ctrl[0];
        core_main[k].irq_ack_id = r_ctrl[5:1];
        core_main[k].instr_req  = r_ctrl[6];
        core_main[k].instr_addr = r_addr;
        core_main[k].data_req   = r_ctrl[7];
        core_data[k].addr       = r_data;
        core_data[k].we         = r_ctrl[8];
        core_wdata[k]           = r_addr ^ r_data;
        core_be[k]              = r_ctrl[12:9];
      end
      #1;
      check_value(32'(irq_ack), 32'(r_ctrl[0]), "voted irq ack");
      check_value(32'(irq_ack_id), 32'(r_ctrl[5:1]), "voted irq ack id");
      check_value(32'(instr_req), 32'(r_ctrl[6]), "voted instr req");
      check_value(instr_addr, r_addr, "voted instr addr");
      check_value(32'(data_req), 32'(r_ctrl[7]), "voted data req");
      check_value(data_addr, r_data, "voted data addr");
      check_value(32'(data_we), 32'(r_ctrl[8]), "voted data we");
      check_value(data_wdata, r_addr ^ r_data, "voted data wdata");
      check_value(32'(data_be), 32'(r_ctrl[12:9]), "voted data be");
      check_value(32'(single_mismatch), 32'd0, "single mismatch on agreement");
      check_value(32'(triple_mismatch), 32'd0, "triple mismatch on agreement");
      wait_cycle();
      check_value(32'(state), 32'(TMR_RUN), "state on agreement");
    end
  endtask

  task automatic write_reg(input logic [31:0] addr, input logic [31:0] wdata);
    reg_req.valid = 1'b1;
    reg_req.write = 1'b1;
    reg_req.addr  = addr[3:0];
    reg_req.wdata = wdata;
    wait_cycle();
    reg_req = '0;
  endtask

  task automatic read_reg(input logic [31:0] addr, input logic [31:0] exp_data,
                          input logic [31:0] exp_err);
    reg_req.valid = 1'b1;
    reg_req.write = 1'b0;
    reg_req.addr  = addr[3:0];
    reg_req.wdata = '0;
    #1;
    check_value(reg_rsp.rdata, exp_data, $sformatf("read data at offset %0h", addr));
    check_value(32'(reg_rsp.error), exp_err, $sformatf("read error at offset %0h", addr));
    reg_req = '0;
  endtask

  // Flags bit 0 grant, bit 1 rvalid, bit 2 error, for both buses
  task automatic check_fanout(input logic [31:0] drdata, input logic [31:0] irdata,
                              input logic [31:0] flags);
    data_rdata   = drdata;
    instr_rdata  = irdata;
    data_gnt     = flags[0];
    data_rvalid  = flags[1];
    data_err     = flags[2];
    instr_gnt    = flags[0];
    instr_rvalid = flags[1];
    instr_err    = flags[2];
    // Control inputs reuse the read data patterns
    hart_id      = irdata;
    boot_addr    = drdata;
    irq          = drdata ^ irdata;
    debug_req    = flags[1];
    #1;
    for (int k = 0; k < 3; k++) begin
      check_value(core_data_rdata[k], drdata, $sformatf("core %0d data rdata", k));
      check_value(core_instr_rdata[k], irdata, $sformatf("core %0d instr rdata", k));
      check_value(32'(core_data_gnt[k]), 32'(flags[0]), $sformatf("core %0d data gnt", k));
      check_value(32'(core_data_rvalid[k]), 32'(flags[1]),
                  $sformatf("core %0d data rvalid", k));
      check_value(32'(core_data_err[k]), 32'(flags[2]), $sformatf("core %0d data err", k));
      check_value(32'(core_instr_gnt[k]), 32'(flags[0]), $sformatf("core %0d instr gnt", k));
      check_value(32'(core_instr_rvalid[k]), 32'(flags[1]),
                  $sformatf("core %0d instr rvalid", k));
      check_value(32'(core_instr_err[k]), 32'(flags[2]), $sformatf("core %0d instr err", k));
      check_value(32'(core_fetch_en[k]), 32'(fetch_en), $sformatf("core %0d fetch en", k));
      check_value(core_hart_id[k], irdata, $sformatf("core %0d hart id", k));
      check_value(core_boot_addr[k], drdata, $sformatf("core %0d boot addr", k));
      check_value(core_irq[k], drdata ^ irdata, $sformatf("core %0d irq", k));
      check_value(32'(core_debug_req[k]), 32'(flags[1]),
                  $sformatf("core %0d debug req", k));
    end
  endtask

  task automatic run_record(input int r);
    for (int w = 0; w < RecWords; w++) begin
      rec[w] = stim_mem[r*RecWords+w];
    end
    case (rec[0])
      32'h1: drive_cores(rec[1], rec[2], rec[3], rec[4], rec[5]);
      32'h2: write_reg(rec[1], rec[2]);
      32'h3: read_reg(rec[1], rec[2], rec[3]);
      32'h4: begin
        for (int n = 0; n < int'(rec[1]); n++) begin
          wait_cycle();
        end
      end
      32'h5: begin
        #1;
        check_value(32'(state), rec[1], "recovery state");
        check_value(32'(core_setback), rec[2], "core setback");
      end
      32'h6: begin
        #1;
        check_value(instr_addr, rec[1], "voted instr addr");
        check_value(data_addr, rec[2], "voted data addr");
        check_value(data_wdata, rec[3], "voted data wdata");
        check_value(32'(single_mismatch), rec[4], "single mismatch");
        check_value(32'(triple_mismatch), rec[4], "triple mismatch");
      end
      32'h7: drive_random_agree(int'(rec[1]));
      32'h8: check_fanout(rec[1], rec[2], rec[3]);
      32'h9: fetch_en = rec[1][0];
      32'ha: begin
        $display("Test %0d finished with %0d errors", rec[1], test_errors);
        test_errors = 0;
      end
      default: begin
        $display("Unknown operation %0h in record %0d of the test data", rec[0], r);
        error_count++;
      end
    endcase
  endtask

  initial begin
    rst_n        = 1'b0;
    reg_req      = '0;
    hart_id      = 32'h0000_0000;
    fetch_en     = 1'b1;
    boot_addr    = 32'h1c00_0080;
    irq          = '0;
    debug_req    = 1'b0;
    instr_gnt    = 1'b0;
    instr_rdata  = '0;
    instr_rvalid = 1'b0;
    instr_err    = 1'b0;
    data_gnt     = 1'b0;
    data_rdata   = '0;
    data_rvalid  = 1'b0;
    data_err     = 1'b0;
    core_main    = '0;
    core_data    = '0;
    core_wdata   = '0;
    core_be      = '0;
    rng_state    = 32'hbe28;
    cycle_count  = 0;
    check_count  = 0;
    error_count  = 0;
    test_errors  = 0;

    for (int i = 0; i < MaxRecs*RecWords; i++) begin
      stim_mem[i] = '0;
    end
    $readmemh("bench/tcls_testdata.txt", stim_mem);

    // Records end at the first operation word of zero
    num_recs = 0;
    max_step = 1;
    while (num_recs < MaxRecs && stim_mem[num_recs*RecWords] != 32'h0) begin
      if (stim_mem[num_recs*RecWords] == 32'h4 || stim_mem[num_recs*RecWords] == 32'h7) begin
        if (int'(stim_mem[num_recs*RecWords+1]) > max_step) begin
          max_step = int'(stim_mem[num_recs*RecWords+1]);
        end
      end
      num_recs++;
    end
    timeout_limit = num_recs * max_step + Margin;

    repeat (3) @(posedge clk);
    #2;
    rst_n = 1'b1;

    if (num_recs == 0) begin
      $display("No records were read from the test data file");
      error_count++;
    end else begin
      for (int r = 0; r < num_recs; r++) begin
        run_record(r);
      end
    end

    $display("%0d checks done, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- source/tcls_unit.sv
/*
 * Top level of the triple-core lock-step unit.
 * Sits between three lock-stepped cores and one interconnect. Core
 * requests are voted onto the interconnect, responses and control
 * inputs are copied to every core, and mismatches drive recovery.
 */
`timescale 1ns/1ps
`default_nettype none

module tcls_unit
  import tcls_pkg::*;
#(
  parameter int unsigned DataWidth = 32,
  parameter int unsigned BeWidth   = 4
) (
  input  wire  logic                                 clk_i,
  input  wire  logic                                 rst_ni,
  input  wire  reg_req_t                             reg_req_i,
  output reg_rsp_t                                   reg_rsp_o,
  output logic                                       single_mismatch_o,
  output logic                                       triple_mismatch_o,
  output red_mode_e                                  state_o,
  output logic      [NumCores-1:0]                   core_setback_o,
  // Interconnect side
  input  wire  logic [31:0]                          intc_hart_id_i,
  input  wire  logic                                 intc_fetch_en_i,
  input  wire  logic [AddrWidth-1:0]                 intc_boot_addr_i,
  input  wire  logic [31:0]                          intc_irq_i,
  input  wire  logic                                 intc_debug_req_i,
  output logic                                       intc_irq_ack_o,
  output logic      [4:0]                            intc_irq_ack_id_o,
  output logic                                       intc_instr_req_o,
  output logic      [AddrWidth-1:0]                  intc_instr_addr_o,
  input  wire  logic                                 intc_instr_gnt_i,
  input  wire  logic [31:0]                          intc_instr_rdata_i,
  input  wire  logic                                 intc_instr_rvalid_i,
  input  wire  logic                                 intc_instr_err_i,
  output logic                                       intc_data_req_o,
  output logic      [AddrWidth-1:0]                  intc_data_addr_o,
  output logic                                       intc_data_we_o,
  output logic      [DataWidth-1:0]                  intc_data_wdata_o,
  output logic      [BeWidth-1:0]                    intc_data_be_o,
  input  wire  logic                                 intc_data_gnt_i,
  input  wire  logic [DataWidth-1:0]                 intc_data_rdata_i,
  input  wire  logic                                 intc_data_rvalid_i,
  input  wire  logic                                 intc_data_err_i,
  // Core side
  input  wire  main_req_t [NumCores-1:0]             core_main_i,
  input  wire  data_req_t [NumCores-1:0]             core_data_i,
  input  wire  logic [NumCores-1:0][DataWidth-1:0]   core_wdata_i,
  input  wire  logic [NumCores-1:0][BeWidth-1:0]     core_be_i,
  output logic      [NumCores-1:0][31:0]             core_hart_id_o,
  output logic      [NumCores-1:0]                   core_fetch_en_o,
  output logic      [NumCores-1:0][AddrWidth-1:0]    core_boot_addr_o,
  output logic      [NumCores-1:0][31:0]             core_irq_o,
  output logic      [NumCores-1:0]                   core_debug_req_o,
  output logic      [NumCores-1:0]                   core_instr_gnt_o,
  output logic      [NumCores-1:0][31:0]             core_instr_rdata_o,
  output logic      [NumCores-1:0]                   core_instr_rvalid_o,
  output logic      [NumCores-1:0]                   core_instr_err_o,
  output logic      [NumCores-1:0]                   core_data_gnt_o,
  output logic      [NumCores-1:0][DataWidth-1:0]    core_data_rdata_o,
  output logic      [NumCores-1:0]                   core_data_rvalid_o,
  output logic      [NumCores-1:0]                   core_data_err_o
);

  main_req_t                 main_vote;
  data_req_t                 data_vote;
  logic      [NumCores-1:0]  error_cba;
  logic      [NumCores-1:0]  mismatch_inc;
  tcls_cfg_t                 cfg;
  logic                      sp_stored;
  logic                      sp_clear;
  logic                      setback;
  logic                      voter_error;

  tcls_core_vote #(
    .DataWidth ( DataWidth ),
    .BeWidth   ( BeWidth   )
  ) i_core_vote (
    .core_main_i  ( core_main_i       ),
    .core_data_i  ( core_data_i       ),
    .core_wdata_i ( core_wdata_i      ),
    .core_be_i    ( core_be_i         ),
    .main_o       ( main_vote         ),
    .data_o       ( data_vote         ),
    .wdata_o      ( intc_data_wdata_o ),
    .be_o         ( intc_data_be_o    ),
    .error_cba_o  ( error_cba         )
  );

  tcls_recovery_fsm i_recovery_fsm (
    .clk_i          ( clk_i           ),
    .rst_ni         ( rst_ni          ),
    .error_cba_i    ( error_cba       ),
    .fetch_en_i     ( intc_fetch_en_i ),
    .cfg_i          ( cfg             ),
    .sp_stored_i    ( sp_stored       ),
    .sp_clear_i     ( sp_clear        ),
    .mismatch_inc_o ( mismatch_inc    ),
    .setback_o      ( setback         ),
    .mode_o         ( state_o         )
  );

  tcls_regs i_regs (
    .clk_i          ( clk_i        ),
    .rst_ni         ( rst_ni       ),
    .reg_req_i      ( reg_req_i    ),
    .mismatch_inc_i ( mismatch_inc ),
    .reg_rsp_o      ( reg_rsp_o    ),
    .cfg_o          ( cfg          ),
    .sp_stored_o    ( sp_stored    ),
    .sp_clear_o     ( sp_clear     )
  );

  // Any core off the majority counts for both status outputs
  assign voter_error       = |error_cba;
  assign single_mismatch_o = (error_cba != '0);
  assign triple_mismatch_o = voter_error;
  assign core_setback_o    = {NumCores{setback}};

  // Voted request onto the interconnect
  assign intc_irq_ack_o    = main_vote.irq_ack;
  assign intc_irq_ack_id_o = main_vote.irq_ack_id;
  assign intc_instr_req_o  = main_vote.instr_req;
  assign intc_instr_addr_o = main_vote.instr_addr;
  assign intc_data_req_o   = main_vote.data_req;
  assign intc_data_addr_o  = data_vote.addr;
  assign intc_data_we_o    = data_vote.we;

  // Every core sees the same responses and control inputs
  always_comb begin
    for (int i = 0; i < NumCores; i++) begin
      core_hart_id_o[i]      = intc_hart_id_i;
      core_fetch_en_o[i]     = intc_fetch_en_i;
      core_boot_addr_o[i]    = intc_boot_addr_i;
      core_irq_o[i]          = intc_irq_i;
      core_debug_req_o[i]    = intc_debug_req_i;
      core_instr_gnt_o[i]    = intc_instr_gnt_i;
      core_instr_rdata_o[i]  = intc_instr_rdata_i;
      core_instr_rvalid_o[i] = intc_instr_rvalid_i;
      core_instr_err_o[i]    = intc_instr_err_i;
      core_data_gnt_o[i]     = intc_data_gnt_i;
      core_data_rdata_o[i]   = intc_data_rdata_i;
      core_data_rvalid_o[i]  = intc_data_rvalid_i;
      core_data_err_o[i]     = intc_data_err_i;
    end
  end

endmodule

`default_nettype wire

//--- source/tcls_recovery_fsm.sv
/*
 * Recovery state machine of the lock-step unit.
 * A mismatch in run mode is counted per core and starts an unload.
 * Software saves state into the stack-pointer store, which moves the
 * unit to reload, and clears it again once state is restored.
 * Setback to the cores is a registered single-cycle pulse.
 */
`timescale 1ns/1ps
`default_nettype none

module tcls_recovery_fsm
  import tcls_pkg::*;
(
  input  wire  logic                clk_i,
  input  wire  logic                rst_ni,
  input  wire  logic [NumCores-1:0] error_cba_i,
  input  wire  logic                fetch_en_i,
  input  wire  tcls_cfg_t           cfg_i,
  input  wire  logic                sp_stored_i,
  input  wire  logic                sp_clear_i,
  output logic [NumCores-1:0]       mismatch_inc_o,
  output logic                      setback_o,
  output red_mode_e                 mode_o
);

  red_mode_e mode_d, mode_q;
  logic      setback_d, setback_q;
  logic      any_error;

  assign any_error = |error_cba_i;

  // Counting only happens on the first mismatch in run mode
  assign mismatch_inc_o = (mode_q == TMR_RUN) ? error_cba_i : '0;

  always_comb begin
    mode_d    = mode_q;
    setback_d = 1'b0;
    case (mode_q)
      TMR_RUN: begin
        if (any_error) begin
          mode_d = TMR_UNLOAD;
        end
      end
      TMR_UNLOAD: begin
        if (sp_stored_i) begin
          mode_d    = TMR_RELOAD;
          setback_d = cfg_i.setback;
        end
      end
      TMR_RELOAD: begin
        if (!sp_stored_i) begin
          mode_d = TMR_RUN;
        end else if (any_error && cfg_i.setback && cfg_i.reload_setback && !sp_clear_i) begin
          setback_d = 1'b1;
        end
      end
      default: mode_d = TMR_RUN;
    endcase
    // Cores halted, nothing left to recover
    if (!fetch_en_i) begin
      mode_d = TMR_RUN;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mode_q    <= TMR_RUN;
      setback_q <= 1'b0;
    end else begin
      mode_q    <= mode_d;
      setback_q <= setback_d;
    end
  end

  assign setback_o = setback_q;
  assign mode_o    = mode_q;

endmodule

`default_nettype wire

//--- source/tcls_regs.sv
/*
 * Register block of the lock-step unit.
 * Holds the configuration, the stack-pointer store used by the
 * recovery software and one saturating mismatch counter per core.
 * Writes land on the next edge, reads return in the same cycle.
 */
`timescale 1ns/1ps
`default_nettype none

module tcls_regs
  import tcls_pkg::*;
(
  input  wire  logic                clk_i,
  input  wire  logic                rst_ni,
  input  wire  reg_req_t            reg_req_i,
  input  wire  logic [NumCores-1:0] mismatch_inc_i,
  output reg_rsp_t                  reg_rsp_o,
  output tcls_cfg_t                 cfg_o,
  output logic                      sp_stored_o,
  output logic                      sp_clear_o
);

  tcls_cfg_t                      cfg_q;
  logic      [31:0]               sp_store_q;
  logic      [NumCores-1:0][31:0] mismatch_q;
  logic                           wr_en;

  assign wr_en = reg_req_i.valid & reg_req_i.write;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_q      <= '0;
      sp_store_q <= '0;
    end else if (wr_en) begin
      if (reg_req_i.addr == REG_CONFIG) begin
        cfg_q <= tcls_cfg_t'(reg_req_i.wdata[$bits(tcls_cfg_t)-1:0]);
      end
      if (reg_req_i.addr == REG_SP_STORE) begin
        sp_store_q <= reg_req_i.wdata;
      end
    end
  end

  // Counters are read-only and stop at all ones
  for (genvar i = 0; i < NumCores; i++) begin : gen_counter
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        mismatch_q[i] <= '0;
      end else if (mismatch_inc_i[i] && (mismatch_q[i] != '1)) begin
        mismatch_q[i] <= mismatch_q[i] + 32'd1;
      end
    end
  end

  always_comb begin
    reg_rsp_o = '0;
    case (reg_req_i.addr)
      REG_CONFIG:     reg_rsp_o.rdata = 32'(cfg_q);
      REG_SP_STORE:   reg_rsp_o.rdata = sp_store_q;
      REG_MISMATCH_0: reg_rsp_o.rdata = mismatch_q[0];
      REG_MISMATCH_1: reg_rsp_o.rdata = mismatch_q[1];
      REG_MISMATCH_2: reg_rsp_o.rdata = mismatch_q[2];
      default:        reg_rsp_o.error = reg_req_i.valid;
    endcase
  end

  assign cfg_o       = cfg_q;
  assign sp_stored_o = (sp_store_q != '0);
  assign sp_clear_o  = wr_en && (reg_req_i.addr == REG_SP_STORE) && (reg_req_i.wdata == '0);

endmodule

`default_nettype wire

//--- source/tcls_core_vote.sv
/*
 * Input side of the lock-step unit.
 * Votes the three core request bundles into one request for the
 * interconnect and reports which cores disagree. Data fields only
 * count as a disagreement while the voted data request is high.
 */
`timescale 1ns/1ps
`default_nettype none

module tcls_core_vote
  import tcls_pkg::*;
#(
  parameter int unsigned DataWidth = 32,
  parameter int unsigned BeWidth   = 4
) (
  input  wire main_req_t [NumCores-1:0]                core_main_i,
  input  wire data_req_t [NumCores-1:0]                core_data_i,
  input  wire logic      [NumCores-1:0][DataWidth-1:0] core_wdata_i,
  input  wire logic      [NumCores-1:0][BeWidth-1:0]   core_be_i,
  output main_req_t                                    main_o,
  output data_req_t                                    data_o,
  output logic           [DataWidth-1:0]               wdata_o,
  output logic           [BeWidth-1:0]                 be_o,
  output logic           [2:0]                         error_cba_o
);

  localparam int unsigned MainWidth = $bits(main_req_t);
  localparam int unsigned DataTmrWidth = $bits(data_req_t) + DataWidth + BeWidth;

  logic [MainWidth-1:0]                   main_vote;
  logic [NumCores-1:0][DataTmrWidth-1:0]  data_word;
  logic [DataTmrWidth-1:0]                data_vote;
  logic [2:0]                             main_error_cba;
  logic [2:0]                             data_error_cba;

  tmr_voter #(
    .Width ( MainWidth )
  ) i_main_voter (
    .a_i         ( core_main_i[0] ),
    .b_i         ( core_main_i[1] ),
    .c_i         ( core_main_i[2] ),
    .majority_o  ( main_vote      ),
    .error_cba_o ( main_error_cba )
  );

  // One word per core so a single voter covers all data fields
  for (genvar i = 0; i < NumCores; i++) begin : gen_data_word
    assign data_word[i] = {core_data_i[i], core_wdata_i[i], core_be_i[i]};
  end

  tmr_voter #(
    .Width ( DataTmrWidth )
  ) i_data_voter (
    .a_i         ( data_word[0]   ),
    .b_i         ( data_word[1]   ),
    .c_i         ( data_word[2]   ),
    .majority_o  ( data_vote      ),
    .error_cba_o ( data_error_cba )
  );

  assign main_o = main_req_t'(main_vote);
  assign {data_o, wdata_o, be_o} = data_vote;

  // Data lines are stale while no access is made
  assign error_cba_o = main_error_cba | (main_o.data_req ? data_error_cba : 3'b000);

endmodule

`default_nettype wire

//--- source/tmr_voter.sv
/*
 * Bitwise two-of-three majority voter.
 * Every output bit follows at least two of the three inputs. The
 * disagreement vector flags each core whose word is not the majority.
 */
`timescale 1ns/1ps
`default_nettype none

module tmr_voter #(
  parameter int unsigned Width = 32
) (
  input  wire logic [Width-1:0] a_i,
  input  wire logic [Width-1:0] b_i,
  input  wire logic [Width-1:0] c_i,
  output logic      [Width-1:0] majority_o,
  output logic      [2:0]       error_cba_o
);

  logic [Width-1:0] majority;

  assign majority = (a_i & b_i) | (a_i & c_i) | (b_i & c_i);

  assign majority_o = majority;

  // Bit 0 belongs to core a, bit 2 to core c
  assign error_cba_o[0] = (a_i != majority);
  assign error_cba_o[1] = (b_i != majority);
  assign error_cba_o[2] = (c_i != majority);

endmodule

`default_nettype wire

//--- source/tcls_pkg.sv
/*
 * Shared types for the triple-core lock-step unit.
 * Holds the bus widths, the per-core request bundles, the register
 * port structs and the recovery state encoding. Modules pull these in
 * with a wildcard import in their header.
 */
`default_nettype none

package tcls_pkg;

  // Core count of the lock-step scheme
  localparam int unsigned NumCores  = 3;
  localparam int unsigned AddrWidth = 32;

  // Fields voted on every cycle
  typedef struct packed {
    logic                 irq_ack;
    logic [4:0]           irq_ack_id;
    logic                 instr_req;
    logic [AddrWidth-1:0] instr_addr;
    logic                 data_req;
  } main_req_t;

  // Fixed-width part of a data access
  // Write data and byte enables travel beside it as vectors
  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    logic                 we;
  } data_req_t;

  typedef enum logic [1:0] {
    TMR_RUN,
    TMR_UNLOAD,
    TMR_RELOAD
  } red_mode_e;

  // Word offsets of the register block
  typedef enum logic [3:0] {
    REG_CONFIG     = 4'd0,
    REG_SP_STORE   = 4'd1,
    REG_MISMATCH_0 = 4'd2,
    REG_MISMATCH_1 = 4'd3,
    REG_MISMATCH_2 = 4'd4
  } reg_addr_e;

  typedef struct packed {
    logic        valid;
    logic        write;
    logic [3:0]  addr;
    logic [31:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        error;
  } reg_rsp_t;

  typedef struct packed {
    logic reload_setback;
    logic setback;
  } tcls_cfg_t;

endpackage

`default_nettype wire
